// File: src/sdCmd_macros.svh
`ifndef SD_CMD_MACROS_SVH
`define SD_CMD_MACROS_SVH

// ======================================================================
// SD command path constants
// ======================================================================

// clk_fast cycles per half period of sdClk
`define SD_CLK_DIV              4

// Command index plus argument
`define SD_CMD_PAYLOAD_BITS     38

// Full command frame on the CMD line
`define SD_CMD_FRAME_BITS       48

// Response frame lengths
`define SD_RESP_SHORT_BITS      48
`define SD_RESP_LONG_BITS       136

`define SD_CRC7_BITS            7

// Leading bits of a long response that the CRC does not cover
`define SD_RESP_LONG_SKIP       8

`endif

// File: src/sdCmdPkg.sv
`default_nettype none

package sdCmdPkg;

    // Response kind requested by a command
    typedef enum logic [1:0] {
        RespNone = 2'b00,
        Resp48   = 2'b01,
        Resp136  = 2'b10
    } sdRespTypeE;

    // One command request, sampled on cmdStart
    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] argument;
        sdRespTypeE  respType;
    } sdCmdReqT;

    typedef struct packed {
        logic crcErr;
        logic endBitErr;
    } sdRespStatusT;

    typedef enum logic [1:0] {
        TxIdle,
        TxPayload,
        TxCrc,
        TxEnd
    } sdTxStateE;

    typedef enum logic [1:0] {
        RxIdle,
        RxWaitStart,
        RxShift,
        RxDone
    } sdRxStateE;

endpackage

`default_nettype wire

// File: src/sdCrc7.sv
`default_nettype none
`timescale 1ns/1ps

`include "sdCmd_macros.svh"

module sdCrc7 (
    input  wire                      clk_fast,
    input  wire                      rstN,
    input  wire                      clear,
    input  wire                      enable,
    input  wire                      dataBit,
    output logic [`SD_CRC7_BITS-1:0] crc
);

    logic feedback;

    // Polynomial x^7 + x^3 + 1, data enters MSB first
    assign feedback = dataBit ^ crc[`SD_CRC7_BITS-1];

    always_ff @(posedge clk_fast or negedge rstN) begin
        if (!rstN) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (enable) begin
            // Tap at x^3 gets the feedback as well as the shift
            crc <= {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
        end
    end

endmodule

`default_nettype wire

// File: src/sdClockGen.sv
`default_nettype none
`timescale 1ns/1ps

`include "sdCmd_macros.svh"

module sdClockGen (
    input  wire  clk_fast,
    input  wire  rstN,
    output logic sdClk,
    output logic shiftTick,
    output logic sampleTick
);

    localparam int CntWidth = $clog2(`SD_CLK_DIV + 1);

    logic [CntWidth-1:0] divCnt;
    logic                edgeNow;

    // Last fast cycle of each sdClk half period
    assign edgeNow = (divCnt == CntWidth'(`SD_CLK_DIV - 1));

    always_ff @(posedge clk_fast or negedge rstN) begin
        if (!rstN) begin
            divCnt     <= '0;
            sdClk      <= 1'b0;
            shiftTick  <= 1'b0;
            sampleTick <= 1'b0;
        end else begin
            // Ticks line up with the first cycle of the new sdClk level
            shiftTick  <= edgeNow && sdClk;
            sampleTick <= edgeNow && !sdClk;
            if (edgeNow) begin
                divCnt <= '0;
                sdClk  <= !sdClk;
            end else begin
                divCnt <= divCnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/sdCmdTx.sv
`default_nettype none
`timescale 1ns/1ps

`include "sdCmd_macros.svh"

module sdCmdTx import sdCmdPkg::*; (
    input  wire        clk_fast,
    input  wire        rstN,
    input  wire        shiftTick,
    input  wire        cmdStart,
    input  wire        sdCmdReqT cmdReq,
    output logic       cmdOut,
    output logic       cmdOe,
    output logic       cmdDone,
    output logic       rxArm,
    output logic       rxAbort,
    output sdRespTypeE respType
);

    // Start bit, transmission bit, index and argument
    localparam int PayloadLen = `SD_CMD_FRAME_BITS - `SD_CRC7_BITS - 1;

    sdTxStateE                      state;
    logic [5:0]                     bitCnt;
    sdCmdReqT                       reqLatch;
    logic [`SD_CMD_PAYLOAD_BITS+1:0] shiftReg;
    logic [`SD_CRC7_BITS-1:0]       crc;
    logic                           crcEnable;

    // A new command always kills a pending response
    assign rxAbort  = cmdStart;
    assign respType = reqLatch.respType;

    assign crcEnable = shiftTick && (state == TxPayload) && !cmdStart;

    sdCrc7 u_crc (
        .clk_fast (clk_fast),
        .rstN     (rstN),
        .clear    (cmdStart),
        .enable   (crcEnable),
        .dataBit  (shiftReg[PayloadLen-1]),
        .crc      (crc)
    );

    // Request and outgoing payload
    always_ff @(posedge clk_fast) begin
        if (cmdStart) begin
            reqLatch <= cmdReq;
            shiftReg <= {1'b0, 1'b1, cmdReq.index, cmdReq.argument};
        end else if (shiftTick && (state == TxPayload)) begin
            shiftReg <= shiftReg << 1;
        end
    end

    // ==================================================================
    // Transmit FSM, one bit per shiftTick
    // ==================================================================
    always_ff @(posedge clk_fast or negedge rstN) begin
        if (!rstN) begin
            state   <= TxIdle;
            bitCnt  <= '0;
            cmdOut  <= 1'b1;
            cmdOe   <= 1'b0;
            cmdDone <= 1'b0;
            rxArm   <= 1'b0;
        end else begin
            cmdDone <= 1'b0;
            rxArm   <= 1'b0;
            if (cmdStart) begin
                // Line keeps its level until the next falling sdClk
                state  <= TxPayload;
                bitCnt <= 6'(PayloadLen - 1);
            end else if (shiftTick) begin
                case (state)
                    TxPayload: begin
                        cmdOut <= shiftReg[PayloadLen-1];
                        cmdOe  <= 1'b1;
                        if (bitCnt == '0) begin
                            state  <= TxCrc;
                            bitCnt <= 6'(`SD_CRC7_BITS - 1);
                        end else begin
                            bitCnt <= bitCnt - 1'b1;
                        end
                    end
                    TxCrc: begin
                        // CRC is frozen here, read it out MSB first
                        cmdOut <= crc[bitCnt[2:0]];
                        if (bitCnt == '0) begin
                            state  <= TxEnd;
                            bitCnt <= 6'd1;
                        end else begin
                            bitCnt <= bitCnt - 1'b1;
                        end
                    end
                    TxEnd: begin
                        if (bitCnt != '0) begin
                            // End bit
                            cmdOut <= 1'b1;
                            bitCnt <= '0;
                        end else begin
                            cmdOut  <= 1'b1;
                            cmdOe   <= 1'b0;
                            cmdDone <= 1'b1;
                            rxArm   <= (reqLatch.respType != RespNone);
                            state   <= TxIdle;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: src/sdRespRx.sv
`default_nettype none
`timescale 1ns/1ps

`include "sdCmd_macros.svh"

module sdRespRx import sdCmdPkg::*; (
    input  wire                           clk_fast,
    input  wire                           rstN,
    input  wire                           sampleTick,
    input  wire                           cmdIn,
    input  wire                           rxArm,
    input  wire                           rxAbort,
    input  wire sdRespTypeE               respType,
    output logic                          respDone,
    output logic [`SD_RESP_LONG_BITS-1:0] respData,
    output sdRespStatusT                  respStatus
);

    // Counter values bounding the CRC window, counted down to the end bit
    localparam int ShortTop = `SD_RESP_SHORT_BITS - 1;
    localparam int LongTop  = `SD_RESP_LONG_BITS - `SD_RESP_LONG_SKIP;
    localparam int CrcLow   = `SD_CRC7_BITS + 2;
    localparam int PadBits  = `SD_RESP_LONG_BITS - `SD_RESP_SHORT_BITS;

    sdRxStateE                     state;
    logic [7:0]                    bitCnt;
    logic                          isLong;
    logic [`SD_RESP_LONG_BITS-1:0] shiftReg;
    logic [`SD_RESP_LONG_BITS-1:0] frameNext;
    logic [7:0]                    crcTop;
    logic                          crcEnable;
    logic                          lastBit;
    logic                          publish;
    logic [`SD_CRC7_BITS-1:0]      crc;

    assign frameNext = {shiftReg[`SD_RESP_LONG_BITS-2:0], cmdIn};
    assign crcTop    = isLong ? 8'(LongTop) : 8'(ShortTop);

    assign crcEnable = sampleTick && (state == RxShift)
                       && (bitCnt <= crcTop) && (bitCnt >= 8'(CrcLow));

    // bitCnt reaches 1 on the end bit
    assign lastBit = sampleTick && (state == RxShift) && (bitCnt == 8'd1);
    assign publish = lastBit && !rxAbort && !rxArm;

    sdCrc7 u_crc (
        .clk_fast (clk_fast),
        .rstN     (rstN),
        .clear    (rxArm),
        .enable   (crcEnable),
        .dataBit  (cmdIn),
        .crc      (crc)
    );

    // ==================================================================
    // Receive FSM
    // ==================================================================
    always_ff @(posedge clk_fast or negedge rstN) begin
        if (!rstN) begin
            state    <= RxIdle;
            bitCnt   <= '0;
            isLong   <= 1'b0;
            respDone <= 1'b0;
        end else begin
            respDone <= 1'b0;
            if (rxAbort) begin
                state <= RxIdle;
            end else if (rxArm) begin
                state  <= RxWaitStart;
                isLong <= (respType == Resp136);
            end else begin
                case (state)
                    RxWaitStart: begin
                        // No timeout, the card decides when to answer
                        if (sampleTick && !cmdIn) begin
                            state  <= RxShift;
                            bitCnt <= isLong ? 8'(`SD_RESP_LONG_BITS - 1)
                                             : 8'(`SD_RESP_SHORT_BITS - 1);
                        end
                    end
                    RxShift: begin
                        if (sampleTick) begin
                            bitCnt <= bitCnt - 1'b1;
                            if (lastBit) begin
                                state    <= RxDone;
                                respDone <= 1'b1;
                            end
                        end
                    end
                    RxDone: begin
                        state <= RxIdle;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Frame bits and published results
    always_ff @(posedge clk_fast) begin
        if (sampleTick) begin
            shiftReg <= frameNext;
        end
        if (publish) begin
            if (isLong) begin
                respData <= frameNext;
            end else begin
                respData <= {{PadBits{1'b0}}, frameNext[`SD_RESP_SHORT_BITS-1:0]};
            end
            // Received CRC field sits just above the incoming end bit
            respStatus.crcErr    <= (crc != shiftReg[`SD_CRC7_BITS-1:0]);
            respStatus.endBitErr <= !cmdIn;
        end
    end

endmodule

`default_nettype wire

// File: src/sdCmdController.sv
`default_nettype none
`timescale 1ns/1ps

`include "sdCmd_macros.svh"

module sdCmdController import sdCmdPkg::*; (
    input  wire                           clk_fast,
    input  wire                           rstN,
    // Command request
    input  wire                           cmdStart,
    input  wire sdCmdReqT                 cmdReq,
    output logic                          cmdDone,
    // Response
    output logic                          respDone,
    output logic [`SD_RESP_LONG_BITS-1:0] respData,
    output sdRespStatusT                  respStatus,
    // SD card CMD line and clock
    output logic                          sdClk,
    output logic                          cmdOut,
    output logic                          cmdOe,
    input  wire                           cmdIn
);

    logic       shiftTick;
    logic       sampleTick;
    logic       rxArm;
    logic       rxAbort;
    sdRespTypeE respType;

    // ======================================================================
    // SD clock and bit timing
    // ======================================================================
    sdClockGen u_clockGen (
        .clk_fast   (clk_fast),
        .rstN       (rstN),
        .sdClk      (sdClk),
        .shiftTick  (shiftTick),
        .sampleTick (sampleTick)
    );

    // ======================================================================
    // Command out and response in
    // ======================================================================
    sdCmdTx u_tx (
        .clk_fast  (clk_fast),
        .rstN      (rstN),
        .shiftTick (shiftTick),
        .cmdStart  (cmdStart),
        .cmdReq    (cmdReq),
        .cmdOut    (cmdOut),
        .cmdOe     (cmdOe),
        .cmdDone   (cmdDone),
        .rxArm     (rxArm),
        .rxAbort   (rxAbort),
        .respType  (respType)
    );

    sdRespRx u_rx (
        .clk_fast   (clk_fast),
        .rstN       (rstN),
        .sampleTick (sampleTick),
        .cmdIn      (cmdIn),
        .rxArm      (rxArm),
        .rxAbort    (rxAbort),
        .respType   (respType),
        .respDone   (respDone),
        .respData   (respData),
        .respStatus (respStatus)
    );

endmodule

`default_nettype wire

// File: dv/sdCmd_assertions.sv
`default_nettype none
`timescale 1ns/1ps

module sdCmdAssertions import sdCmdPkg::*; (
    input wire             clk_fast,
    input wire             rstN,
    input wire             cmdDone,
    input wire             respDone,
    input wire             cmdOut,
    input wire             cmdOe,
    input wire             shiftTick,
    input wire sdTxStateE  txState,
    input wire sdRxStateE  rxState
);

    int failCount = 0;

    // Done strobes last a single cycle
    assert property (@(posedge clk_fast) disable iff (!rstN) cmdDone |=> !cmdDone)
        else begin
            failCount++;
            $error("cmdDone held longer than one cycle");
        end
    assert property (@(posedge clk_fast) disable iff (!rstN) respDone |=> !respDone)
        else begin
            failCount++;
            $error("respDone held longer than one cycle");
        end

    // CMD line only moves on a shiftTick
    assert property (@(posedge clk_fast) disable iff (!rstN)
                     (cmdOe && !shiftTick) |=> $stable(cmdOut))
        else begin
            failCount++;
            $error("cmdOut changed outside shiftTick");
        end

    // Output enable drops together with cmdDone
    assert property (@(posedge clk_fast) disable iff (!rstN) $fell(cmdOe) |-> cmdDone)
        else begin
            failCount++;
            $error("cmdOe fell without cmdDone");
        end
    assert property (@(posedge clk_fast) disable iff (!rstN) cmdDone |-> $fell(cmdOe))
        else begin
            failCount++;
            $error("cmdDone without cmdOe falling");
        end

    // Receiver only listens while the host has released the CMD line
    assert property (@(posedge clk_fast) disable iff (!rstN) (rxState != RxIdle) |-> !cmdOe)
        else begin
            failCount++;
            $error("receiver active while cmdOe high");
        end
    // A response never completes with a command in flight
    assert property (@(posedge clk_fast) disable iff (!rstN)
                     respDone |-> (txState == TxIdle))
        else begin
            failCount++;
            $error("respDone while the transmitter is busy");
        end

endmodule

bind sdCmdController sdCmdAssertions u_assertions (
    .clk_fast  (clk_fast),
    .rstN      (rstN),
    .cmdDone   (cmdDone),
    .respDone  (respDone),
    .cmdOut    (cmdOut),
    .cmdOe     (cmdOe),
    .shiftTick (shiftTick),
    .txState   (u_tx.state),
    .rxState   (u_rx.state)
);

`default_nettype wire

// File: dv/sdCmdChecker.sv
`default_nettype none
`timescale 1ns/1ps

`include "sdCmd_macros.svh"

module sdCmdChecker import sdCmdPkg::*; (
    input  wire                           clk_fast,
    input  wire                           rstN,
    input  wire                           cmdStart,
    input  wire                           cmdDone,
    input  wire                           respDone,
    input  wire                           sdClk,
    input  wire                           cmdOut,
    input  wire                           cmdOe,
    input  wire [`SD_RESP_LONG_BITS-1:0]  respData,
    input  wire sdRespStatusT             respStatus,
    // Expected values from the testbench model
    input  wire sdCmdReqT                 expReq,
    input  wire [`SD_CRC7_BITS-1:0]       expCmdCrc,
    input  wire [`SD_RESP_LONG_BITS-1:0]  expData,
    input  wire                           expCrcErr,
    input  wire                           expEndBitErr,
    input  wire [31:0]                    expSeq,
    output int                            valueErrors,
    output int                            protocolErrors
);

    logic [`SD_CMD_FRAME_BITS-1:0] frame;
    logic [31:0]                   seq;
    int                            edges;
    int                            halfCnt;
    logic                          sdClkPrev;
    logic                          gotResp;

    task automatic compareValue(input string name, input logic [135:0] got,
                                input logic [135:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %0h expected %0h", name, got, exp);
            valueErrors++;
        end
    endtask

    // ==================================================================
    // Command frame decode and response compare
    // ==================================================================
    always @(posedge clk_fast or negedge rstN) begin
        if (!rstN) begin
            frame          <= '0;
            seq            <= '0;
            edges          <= 0;
            halfCnt        <= 0;
            sdClkPrev      <= 1'b0;
            gotResp        <= 1'b0;
            valueErrors    = 0;
            protocolErrors = 0;
        end else begin
            sdClkPrev <= sdClk;
            // sdClk holds each level for SD_CLK_DIV fast cycles
            if (sdClk != sdClkPrev) begin
                compareValue("sdClkHalfPeriod", halfCnt, `SD_CLK_DIV);
                halfCnt <= 1;
            end else begin
                halfCnt <= halfCnt + 1;
            end
            if (cmdStart) begin
                edges   <= 0;
                seq     <= seq + 1'b1;
                gotResp <= 1'b0;
            end else if (sdClk && !sdClkPrev && cmdOe) begin
                // Card side view of the CMD line
                frame <= {frame[`SD_CMD_FRAME_BITS-2:0], cmdOut};
                edges <= edges + 1;
            end
            if (cmdDone) begin
                compareValue("cmdEdges", edges, `SD_CMD_FRAME_BITS);
                compareValue("cmdStartBit", frame[47], 1'b0);
                compareValue("cmdTransmissionBit", frame[46], 1'b1);
                compareValue("cmdIndex", frame[45:40], expReq.index);
                compareValue("cmdArgument", frame[39:8], expReq.argument);
                compareValue("cmdCrc", frame[7:1], expCmdCrc);
                compareValue("cmdEndBit", frame[0], 1'b1);
            end
            if (respDone) begin
                if ((expSeq != seq) || gotResp) begin
                    $display("Error: respDone with no response outstanding for command %0d",
                             seq);
                    protocolErrors++;
                end else begin
                    gotResp <= 1'b1;
                    compareValue("respData", respData, expData);
                    compareValue("respStatus.crcErr", respStatus.crcErr, expCrcErr);
                    compareValue("respStatus.endBitErr", respStatus.endBitErr, expEndBitErr);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/sdCmdTb.sv
`default_nettype none
`timescale 1ns/1ps

`include "sdCmd_macros.svh"

module sdCmdTb import sdCmdPkg::*; ();

    localparam int     NumCmds    = 24;
    localparam int     AbortAt    = 11;
    localparam longint WatchdogNs = (NumCmds + 2) * 200 * 2 * `SD_CLK_DIV * 20;

    logic                          clk_fast = 1'b0;
    logic                          rstN;
    logic                          cmdStart;
    sdCmdReqT                      cmdReq;
    logic                          cmdDone;
    logic                          respDone;
    logic [`SD_RESP_LONG_BITS-1:0] respData;
    sdRespStatusT                  respStatus;
    logic                          sdClk;
    logic                          cmdOut;
    logic                          cmdOe;
    logic                          cmdIn;
    logic [31:0]                   cmdCount;
    logic [`SD_CRC7_BITS-1:0]      expCmdCrc;
    logic [`SD_RESP_LONG_BITS-1:0] expData;
    logic                          expCrcErr;
    logic                          expEndBitErr;
    logic [31:0]                   expSeq;
    int                            valueErrors;
    int                            protocolErrors;
    logic [15:0]                   lfsrState;

    always #10 clk_fast = !clk_fast;

    sdCmdController u_dut (
        .clk_fast (clk_fast), .rstN (rstN), .cmdStart (cmdStart), .cmdReq (cmdReq),
        .cmdDone (cmdDone), .respDone (respDone), .respData (respData),
        .respStatus (respStatus), .sdClk (sdClk), .cmdOut (cmdOut), .cmdOe (cmdOe),
        .cmdIn (cmdIn)
    );

    sdCmdChecker u_checker (
        .clk_fast (clk_fast), .rstN (rstN), .cmdStart (cmdStart), .cmdDone (cmdDone),
        .respDone (respDone), .sdClk (sdClk), .cmdOut (cmdOut), .cmdOe (cmdOe),
        .respData (respData), .respStatus (respStatus), .expReq (cmdReq),
        .expCmdCrc (expCmdCrc), .expData (expData), .expCrcErr (expCrcErr),
        .expEndBitErr (expEndBitErr), .expSeq (expSeq), .valueErrors (valueErrors),
        .protocolErrors (protocolErrors)
    );

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] nextLfsr(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [135:0] randomBits(input int count);
        logic [135:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = nextLfsr(lfsrState);
            value     = {value[134:0], lfsrState[0]};
        end
        return value;
    endfunction

    // CRC7 over frame bits first..last, frame bit 0 is the MSB of a len-bit frame
    function automatic logic [6:0] crc7Of(input logic [135:0] frame, input int len,
                                          input int first, input int last);
        logic [6:0] crc;
        logic       feedback;
        crc = '0;
        for (int k = first; k <= last; k++) begin
            feedback = frame[len - 1 - k] ^ crc[6];
            crc      = {crc[5:0], 1'b0} ^ (feedback ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    task automatic sendCommand(input logic withAbort);
        sdCmdReqT     req;
        logic [135:0] pick;
        pick         = randomBits(6);
        req.index    = pick[5:0];
        pick         = randomBits(32);
        req.argument = pick[31:0];
        pick         = randomBits(2);
        req.respType = (pick[1:0] == 2'd0) ? RespNone : (pick[1] ? Resp136 : Resp48);
        if (withAbort) begin
            req.respType = Resp136;
        end
        @(posedge clk_fast);
        cmdReq    <= req;
        cmdStart  <= 1'b1;
        cmdCount  <= cmdCount + 1'b1;
        expCmdCrc <= crc7Of({96'b0, 2'b01, req.index, req.argument}, 40, 0, 39);
        @(posedge clk_fast);
        cmdStart <= 1'b0;
        do @(posedge clk_fast); while (!cmdDone);
        if (withAbort) begin
            // Let the response get well under way, the next command cuts it off
            do @(posedge clk_fast); while (cmdIn);
            repeat (30) @(negedge sdClk);
        end else if (req.respType == RespNone) begin
            repeat (20) @(negedge sdClk);
        end else begin
            do @(posedge clk_fast); while (!respDone);
        end
        repeat (4) @(posedge clk_fast);
    endtask

    // ==================================================================
    // Card model on the CMD line
    // ==================================================================
    initial begin : cardResponder
        logic [135:0] frame;
        logic [135:0] pick;
        logic [6:0]   crc;
        logic         crcFlip;
        logic         endZero;
        logic [31:0]  mySeq;
        int           len;
        int           gap;
        int           k;
        cmdIn        = 1'b1;
        expData      = '0;
        expCrcErr    = 1'b0;
        expEndBitErr = 1'b0;
        expSeq       = '0;
        forever begin
            // Let the whole command frame go by
            for (int i = 0; i < `SD_CMD_FRAME_BITS; i++) begin
                do @(posedge sdClk); while (!cmdOe);
            end
            mySeq = cmdCount;
            if (cmdReq.respType != RespNone) begin
                len  = (cmdReq.respType == Resp136) ? `SD_RESP_LONG_BITS : `SD_RESP_SHORT_BITS;
                pick = randomBits(3);
                gap  = 1 + pick[2:0];
                frame = randomBits(len);
                frame[len - 1] = 1'b0;
                frame[len - 2] = 1'b0;
                crc = crc7Of(frame, len, (len == `SD_RESP_LONG_BITS) ? 8 : 0, len - 9);
                pick    = randomBits(2);
                crcFlip = (pick[1:0] == 2'd0);
                if (crcFlip) begin
                    pick = randomBits(3);
                    crc  = crc ^ (7'h01 << (pick[2:0] % 7));
                end
                pick       = randomBits(3);
                endZero    = (pick[2:0] == 3'd0);
                frame[7:1] = crc;
                frame[0]   = !endZero;
                repeat (gap) @(negedge sdClk);
                @(posedge clk_fast);
                expData      <= frame;
                expCrcErr    <= crcFlip;
                expEndBitErr <= endZero;
                expSeq       <= mySeq;
                // Bits change after sdClk falls, a new command stops the response
                k = len - 1;
                while ((k >= 0) && (cmdCount == mySeq)) begin
                    @(negedge sdClk);
                    @(posedge clk_fast);
                    if (cmdCount == mySeq) begin
                        cmdIn <= frame[k];
                    end
                    k--;
                end
                if (cmdCount == mySeq) begin
                    @(negedge sdClk);
                    @(posedge clk_fast);
                end
                cmdIn <= 1'b1;
            end
        end
    end

    initial begin : mainSequence
        lfsrState = 16'd96;
        rstN      = 1'b0;
        cmdStart  = 1'b0;
        cmdReq    = '0;
        cmdCount  = '0;
        expCmdCrc = '0;
        repeat (16) @(posedge clk_fast);
        rstN <= 1'b1;
        repeat (4) @(posedge clk_fast);
        for (int n = 0; n < NumCmds; n++) begin
            sendCommand(n == AbortAt);
        end
        repeat (20) @(posedge clk_fast);
        $display(
            "Summary: %0d commands, %0d value errors, %0d protocol errors, %0d assertion failures",
            NumCmds, valueErrors, protocolErrors, u_dut.u_assertions.failCount);
        if ((valueErrors + protocolErrors + u_dut.u_assertions.failCount) == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        #(WatchdogNs);
        $display("Timeout: the command sequence did not finish within %0d ns", WatchdogNs);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: sdCmdController.f
+incdir+src
src/sdCmdPkg.sv
src/sdCrc7.sv
src/sdClockGen.sv
src/sdCmdTx.sv
src/sdRespRx.sv
src/sdCmdController.sv
dv/sdCmd_assertions.sv
dv/sdCmdChecker.sv
dv/sdCmdTb.sv

// File: Bender.yml
package:
  name: sdCmdController

sources:
  - include_dirs:
      - src
    files:
      - src/sdCmdPkg.sv
      - src/sdCrc7.sv
      - src/sdClockGen.sv
      - src/sdCmdTx.sv
      - src/sdRespRx.sv
      - src/sdCmdController.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/sdCmd_assertions.sv
      - dv/sdCmdChecker.sv
      - dv/sdCmdTb.sv
